/* vlog.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_direct.sv
hdl/line_memory.sv
hdl/cache_subsystem.sv
dv/cache_assert.sv
dv/cache_checker.sv
dv/cache_tb.sv

/* Makefile */
TOP := cache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/cache_tb.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_tb;

	import cache_pkg::*;

	localparam int NUM_ACCESSES = 2000;
	localparam int RESET_CYCLES = 5;
	localparam int WORST_MISS   = 2 * `MEM_LATENCY + 4;
	// Doubled for enable gaps, plus reset and drain
	localparam int MAX_CYCLES   = NUM_ACCESSES * WORST_MISS * 2 + 200;

	logic     clk;
	logic     reset;
	logic     master_enable;
	cpu_req_t cpu_req;
	word_t    data_out;
	logic     hit;

	int unsigned error_count;
	int unsigned read_count;
	int unsigned write_count;
	int unsigned idle_count;
	int unsigned assert_count;
	int unsigned cycle_count = 0;

	////////////////////////////////////////////////////////////
	// DUT, checker and assertions
	////////////////////////////////////////////////////////////

	cache_subsystem i_dut (
		.clk           (clk),
		.reset         (reset),
		.master_enable (master_enable),
		.cpu_req       (cpu_req),
		.data_out      (data_out),
		.hit           (hit)
	);

	cache_checker i_checker (
		.clk           (clk),
		.reset         (reset),
		.master_enable (master_enable),
		.cpu_req       (cpu_req),
		.data_out      (data_out),
		.hit           (hit),
		.error_count   (error_count),
		.read_count    (read_count),
		.write_count   (write_count),
		.idle_count    (idle_count)
	);

	bind cache_direct cache_assert i_assert (
		.clk           (clk),
		.reset         (reset),
		.mem_write_req (mem_write_req),
		.mem_write_ack (mem_write_ack),
		.mem_read_req  (mem_read_req),
		.mem_read_ack  (mem_read_ack)
	);

	assign assert_count = i_dut.i_cache.i_assert.fail_count;

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("Timeout: no completion within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// 16 lines with four per cache index
	function automatic cpu_req_t random_request();
		cpu_req_t   req;
		logic [3:0] line_sel;
		logic [5:0] mem_line;
		logic [3:0] offset;
		line_sel         = 4'($urandom_range(15));
		mem_line         = {line_sel[3:2], 2'b00, line_sel[1:0]};
		offset           = 4'($urandom_range(15));
		req.byte_enable  = ($urandom_range(1) == 1);
		req.write_enable = ($urandom_range(9) < 4); // About 40% writes
		if (!req.byte_enable)
			offset[1:0] = 2'b00; // Word accesses stay aligned
		req.addr = {22'h000000, mem_line, offset};
		req.data = $urandom();
		return req;
	endfunction

	// Holds the request until hit, starting 1 ns after an edge
	task automatic run_access(input cpu_req_t req);
		bit done;
		done    = 1'b0;
		cpu_req = req;
		while (!done) begin
			master_enable = ($urandom_range(7) != 0);
			@(negedge clk);
			done = master_enable && hit;
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		void'($urandom(32'h8f71));
		reset         = 1'b1;
		master_enable = 1'b0;
		cpu_req       = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int n = 0; n < NUM_ACCESSES; n++)
			run_access(random_request());

		master_enable = 1'b0;
		repeat (3) @(posedge clk);
		#1;

		$display("Accesses %0d, reads %0d, writes %0d, idle %0d, errors %0d, assert fails %0d",
			NUM_ACCESSES, read_count, write_count, idle_count, error_count, assert_count);
		if (error_count == 0 && assert_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* dv/cache_checker.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

////////////////////////////////////////////////////////////
// Flat memory model and response checks
////////////////////////////////////////////////////////////

module cache_checker (
	input  logic                clk,
	input  logic                reset,
	input  logic                master_enable,
	input  cache_pkg::cpu_req_t cpu_req,
	input  cache_pkg::word_t    data_out,
	input  logic                hit,
	output int unsigned         error_count,
	output int unsigned         read_count,
	output int unsigned         write_count,
	output int unsigned         idle_count
);

	import cache_pkg::*;

	localparam int MODEL_WORDS = `MEM_LINES * `MEMORY_WIDTH / 32;
	localparam int WI          = $clog2(MODEL_WORDS); // Word index bits

	word_t model [MODEL_WORDS];

	int unsigned errors = 0;
	int unsigned reads  = 0;
	int unsigned writes = 0;
	int unsigned idles  = 0;

	assign error_count = errors;
	assign read_count  = reads;
	assign write_count = writes;
	assign idle_count  = idles;

	// Every word starts out as its own byte address
	initial begin
		for (int w = 0; w < MODEL_WORDS; w++)
			model[w] = word_t'(w * 4);
	end

	function automatic word_t expected_read(input cpu_req_t req);
		word_t w;
		w = model[req.addr[WI+1:2]];
		if (req.byte_enable)
			return {24'h000000, w[req.addr[1:0]*8 +: 8]};
		return w;
	endfunction

	task automatic apply_write(input cpu_req_t req);
		if (req.byte_enable)
			model[req.addr[WI+1:2]][req.addr[1:0]*8 +: 8] = req.data[7:0];
		else
			model[req.addr[WI+1:2]] = req.data;
	endtask

	////////////////////////////////////////////////////////////
	// Sampled mid-cycle, where the DUT outputs are settled
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		word_t expected;
		if (!reset) begin
			if (!master_enable) begin
				idles++;
				if (hit !== 1'b0 || data_out !== '0) begin
					$display("Fail %0t ns: hit %b data_out 0x%h with master_enable low",
						$time, hit, data_out);
					errors++;
				end
			end else if (hit === 1'b1) begin
				if (cpu_req.write_enable) begin
					apply_write(cpu_req); // Commits at the coming edge
					writes++;
				end else begin
					expected = expected_read(cpu_req);
					reads++;
					if (data_out !== expected) begin
						$display("Fail %0t ns: %s read at 0x%h returned 0x%h, expected 0x%h",
							$time, cpu_req.byte_enable ? "byte" : "word",
							cpu_req.addr, data_out, expected);
						errors++;
					end
				end
			end
		end
	end

endmodule

/* dv/cache_assert.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Memory request rules, bound into cache_direct
////////////////////////////////////////////////////////////

module cache_assert (
	input logic clk,
	input logic reset,
	input logic mem_write_req,
	input logic mem_write_ack,
	input logic mem_read_req,
	input logic mem_read_ack
);

	int unsigned fail_count = 0; // Read by the testbench top

	// Fill data never arrives while the victim is still pending
	read_ack_after_write: assert property (@(posedge clk) disable iff (reset)
		mem_read_ack |-> !mem_write_req)
		else begin
			$error("read ack seen while a write-back request is pending");
			fail_count++;
		end

	write_req_holds: assert property (@(posedge clk) disable iff (reset)
		mem_write_req && !mem_write_ack |=> mem_write_req)
		else begin
			$error("write-back request dropped before its ack");
			fail_count++;
		end

	read_req_holds: assert property (@(posedge clk) disable iff (reset)
		mem_read_req && !mem_read_ack |=> mem_read_req)
		else begin
			$error("fill request dropped before its ack");
			fail_count++;
		end

	// Acks only answer a live request
	ack_has_req: assert property (@(posedge clk) disable iff (reset)
		(mem_write_ack |-> mem_write_req) and (mem_read_ack |-> mem_read_req))
		else begin
			$error("ack pulse without a matching request");
			fail_count++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> (!mem_write_req && !mem_read_req))
		else begin
			$error("memory request high in the cycle after reset");
			fail_count++;
		end

endmodule

/* hdl/cache_subsystem.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Cache plus backing memory
////////////////////////////////////////////////////////////

module cache_subsystem (
	input  logic                clk,
	input  logic                reset,
	input  logic                master_enable,
	input  cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::word_t    data_out,
	output logic                hit
);

	import cache_pkg::*;

	// Memory bus, internal only
	logic     mem_write_req;
	mem_req_t mem_wr;
	logic     mem_write_ack;
	logic     mem_read_req;
	addr_t    mem_read_addr;
	line_t    mem_read_data;
	logic     mem_read_ack;

	cache_direct i_cache (
		.clk           (clk),
		.reset         (reset),
		.master_enable (master_enable),
		.cpu_req       (cpu_req),
		.data_out      (data_out),
		.hit           (hit),
		.mem_write_req (mem_write_req),
		.mem_wr        (mem_wr),
		.mem_write_ack (mem_write_ack),
		.mem_read_req  (mem_read_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_read_ack  (mem_read_ack)
	);

	line_memory i_memory (
		.clk           (clk),
		.reset         (reset),
		.mem_write_req (mem_write_req),
		.mem_wr        (mem_wr),
		.mem_write_ack (mem_write_ack),
		.mem_read_req  (mem_read_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_read_ack  (mem_read_ack)
	);

endmodule

/* hdl/line_memory.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

////////////////////////////////////////////////////////////
// Backing line memory, fixed latency
////////////////////////////////////////////////////////////

module line_memory (
	input  logic                clk,
	input  logic                reset,
	input  logic                mem_write_req,
	input  cache_pkg::mem_req_t mem_wr,
	output logic                mem_write_ack,
	input  logic                mem_read_req,
	input  cache_pkg::addr_t    mem_read_addr,
	output cache_pkg::line_t    mem_read_data,
	output logic                mem_read_ack
);

	import cache_pkg::*;

	localparam int WB    = $clog2(`MEMORY_WIDTH / 8); // Byte offset bits
	localparam int LB    = $clog2(`MEM_LINES);        // Line index bits
	localparam int WORDS = `MEMORY_WIDTH / 32;
	localparam int CW    = $clog2(`MEM_LATENCY + 1);

	line_t mem [`MEM_LINES];

	logic [LB-1:0] wr_index;
	logic [LB-1:0] rd_index;
	logic [CW-1:0] count;
	logic          busy_ack; // Ack still visible to the cache
	mem_state_t    state;

	assign wr_index = mem_wr.addr[WB+LB-1:WB];
	assign rd_index = mem_read_addr[WB+LB-1:WB];
	assign busy_ack = mem_write_ack || mem_read_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= mem_idle;
			count         <= '0;
			mem_write_ack <= 1'b0;
			mem_read_ack  <= 1'b0;
			// Each word starts out holding its own byte address
			for (int i = 0; i < `MEM_LINES; i++) begin
				for (int j = 0; j < WORDS; j++) begin
					mem[i][j*32 +: 32] <= word_t'(i * (`MEMORY_WIDTH / 8) + j * 4);
				end
			end
		end else begin
			mem_write_ack <= 1'b0; // Acks are single pulses
			mem_read_ack  <= 1'b0;

			case (state)
				mem_idle: begin
					// Write first, so the victim lands before the fill
					if (!busy_ack && mem_write_req) begin
						state <= mem_writing;
						count <= CW'(`MEM_LATENCY - 1);
					end else if (!busy_ack && mem_read_req) begin
						state <= mem_reading;
						count <= CW'(`MEM_LATENCY - 1);
					end
				end
				mem_writing: begin
					if (count == '0) begin
						mem[wr_index] <= mem_wr.data;
						mem_write_ack <= 1'b1;
						state         <= mem_idle;
					end else
						count <= count - 1'b1;
				end
				mem_reading: begin
					if (count == '0) begin
						mem_read_ack <= 1'b1;
						state        <= mem_idle;
					end else
						count <= count - 1'b1;
				end
				default: state <= mem_idle;
			endcase
		end
	end

	// Read data is valid alongside the ack pulse
	always_ff @(posedge clk) begin
		if (state == mem_reading && count == '0)
			mem_read_data <= mem[rd_index];
	end

endmodule

/* hdl/cache_direct.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

////////////////////////////////////////////////////////////
// Direct-mapped write-back cache
////////////////////////////////////////////////////////////

module cache_direct #(
	parameter int WIDTH = `MEMORY_WIDTH, // Bits per line
	parameter int DEPTH = `CACHE_DEPTH   // Number of lines
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               master_enable,
	input  cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::word_t   data_out,
	output logic               hit,
	// Memory side
	output logic               mem_write_req,
	output cache_pkg::mem_req_t mem_wr,
	input  logic               mem_write_ack,
	output logic               mem_read_req,
	output cache_pkg::addr_t   mem_read_addr,
	input  cache_pkg::line_t   mem_read_data,
	input  logic               mem_read_ack
);

	import cache_pkg::*;

	localparam int WB = $clog2(WIDTH / 8); // Offset bits
	localparam int DB = $clog2(DEPTH);     // Index bits
	localparam int TB = 32 - WB - DB;      // Tag bits

	// Address = tag | index | offset
	logic [WB-1:0] offset;
	logic [DB-1:0] index;
	logic [TB-1:0] tag;
	logic [WB-1:0] word_sel;

	logic [DB-1:0] fill_index;
	logic [TB-1:0] fill_tag;

	logic [DEPTH-1:0] valid_bits;
	logic [DEPTH-1:0] dirty_bits;
	logic [TB-1:0]    tags  [DEPTH];
	logic [WIDTH-1:0] lines [DEPTH];

	logic [WIDTH-1:0] line_out;
	word_t            word_out;
	logic [7:0]       byte_out;

	logic         hit_int;
	logic         hit_write;
	logic         fill_done;
	logic         miss_start;
	cache_state_t state;

	assign offset   = cpu_req.addr[WB-1:0];
	assign index    = cpu_req.addr[WB+DB-1:WB];
	assign tag      = cpu_req.addr[31:WB+DB];
	assign word_sel = offset >> 2; // Word within the line

	assign fill_index = mem_read_addr[WB+DB-1:WB];
	assign fill_tag   = mem_read_addr[31:WB+DB];

	////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////

	assign line_out = lines[index];
	assign word_out = line_out[word_sel*32 +: 32];
	assign byte_out = line_out[offset*8 +: 8];

	assign hit_int = valid_bits[index] && (tags[index] == tag);

	always_comb begin
		if (master_enable && !reset && hit_int) begin
			hit = 1'b1;
			if (cpu_req.byte_enable)
				data_out = {24'h000000, byte_out}; // Zero-extended byte
			else
				data_out = word_out;
		end else begin
			hit      = 1'b0;
			data_out = '0;
		end
	end

	assign hit_write  = master_enable && hit_int && cpu_req.write_enable;
	assign fill_done  = (state == cache_wait_mem) && mem_read_ack && !mem_write_req;
	assign miss_start = (state == cache_idle) && master_enable && !hit_int;

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= cache_idle;
			valid_bits    <= '0;
			dirty_bits    <= '0;
			mem_write_req <= 1'b0;
			mem_read_req  <= 1'b0;
		end else begin
			if (hit_write)
				dirty_bits[index] <= 1'b1;

			case (state)
				cache_idle: begin
					if (miss_start) begin
						// Evict only a dirty victim
						if (valid_bits[index] && dirty_bits[index])
							mem_write_req <= 1'b1;
						valid_bits[index] <= 1'b0;
						mem_read_req      <= 1'b1;
						state             <= cache_wait_mem;
					end
				end
				cache_wait_mem: begin
					if (mem_write_ack)
						mem_write_req <= 1'b0;
					if (fill_done) begin
						valid_bits[fill_index] <= 1'b1;
						dirty_bits[fill_index] <= 1'b0; // Fresh line is clean
						mem_read_req           <= 1'b0;
						state                  <= cache_idle;
					end
				end
				default: state <= cache_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Line data, tags and request payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset && hit_write) begin
			if (cpu_req.byte_enable)
				lines[index][offset*8 +: 8] <= cpu_req.data[7:0];
			else
				lines[index][word_sel*32 +: 32] <= cpu_req.data;
		end

		// Fill index is invalid, so it never collides with a hit write
		if (!reset && fill_done) begin
			lines[fill_index] <= mem_read_data;
			tags[fill_index]  <= fill_tag;
		end

		if (!reset && miss_start) begin
			mem_wr.addr   <= {tags[index], index, {WB{1'b0}}}; // Victim line address
			mem_wr.data   <= lines[index];
			mem_read_addr <= {tag, index, {WB{1'b0}}};
		end
	end

endmodule

/* hdl/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

	typedef logic [31:0]               addr_t; // Byte address
	typedef logic [31:0]               word_t; // Processor word
	typedef logic [`MEMORY_WIDTH-1:0] line_t; // One cache line

	// Processor request, held until hit
	typedef struct packed {
		addr_t addr;
		logic  byte_enable;
		logic  write_enable;
		word_t data;
	} cpu_req_t;

	// Line write-back to memory
	typedef struct packed {
		addr_t addr;
		line_t data;
	} mem_req_t;

	typedef enum logic {
		cache_idle,
		cache_wait_mem
	} cache_state_t;

	typedef enum logic [1:0] {
		mem_idle,
		mem_writing,
		mem_reading
	} mem_state_t;

endpackage

/* hdl/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////

`define MEMORY_WIDTH 128 // Bits per cache line
`define CACHE_DEPTH  4   // Lines in the cache

////////////////////////////////////////////////////////////
// Backing memory
////////////////////////////////////////////////////////////

`define MEM_LINES   64 // Lines in the backing store
`define MEM_LATENCY 3  // Cycles from request seen to ack

`endif
